// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int SB_DEPTH = 8;
    localparam int SB_IDX_W = 3;
    localparam int XLEN     = 32;
    localparam int INST_W   = 32;
    localparam int PHY_W    = 8;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU
    } mem_op_e;

    // RV32 load/store funct3 encodings
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100; // Loads only
    localparam logic [2:0] F3_HU = 3'b101; // Loads only

endpackage

`default_nettype wire

// ==== rtl/lsu_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mem_req_if;
    import lsu_pkg::*;

    logic              valid; // One cycle per request
    mem_op_e           op;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;
    logic [INST_W-1:0] inst_num;
    logic [PHY_W-1:0]  phy;

    modport src (output valid, op, addr, data, inst_num, phy);
    modport dst (input valid, op, addr, data, inst_num, phy);
endinterface

interface lookup_if;
    import lsu_pkg::*;

    logic              done; // One pulse per load
    logic              hit;
    logic [XLEN-1:0]   raw;
    mem_op_e           op;
    logic [PHY_W-1:0]  phy;
    logic [INST_W-1:0] inst_num;

    modport src (output done, hit, raw, op, phy, inst_num);
    modport dst (input done, hit, raw, op, phy, inst_num);
endinterface

`default_nettype wire

// ==== rtl/lsu_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_dispatch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       mem_write,
    input  logic                       mem_read,
    input  logic [2:0]                 funct3,
    input  logic [lsu_pkg::XLEN-1:0]   mem_addr,
    input  logic [lsu_pkg::XLEN-1:0]   mem_data,
    input  logic [lsu_pkg::INST_W-1:0] inst_num,
    input  logic [lsu_pkg::PHY_W-1:0]  load_phy,
    mem_req_if.src                     req
);
    import lsu_pkg::*;

    mem_op_e op_d;
    logic    valid_q;

    always_comb begin
        op_d = OP_NONE;
        if (mem_write) begin // Write wins over read
            case (funct3)
                F3_B:    op_d = OP_SB;
                F3_H:    op_d = OP_SH;
                F3_W:    op_d = OP_SW;
                default: op_d = OP_NONE;
            endcase
        end else if (mem_read) begin
            case (funct3)
                F3_B:    op_d = OP_LB;
                F3_H:    op_d = OP_LH;
                F3_W:    op_d = OP_LW;
                F3_BU:   op_d = OP_LBU;
                F3_HU:   op_d = OP_LHU;
                default: op_d = OP_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= (op_d != OP_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (op_d != OP_NONE) begin
            req.op       <= op_d;
            req.addr     <= mem_addr;
            req.data     <= mem_data;
            req.inst_num <= inst_num;
            req.phy      <= load_phy;
        end
    end

    assign req.valid = valid_q && !flush; // Flush kills the held request

    a_req_op: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> (req.op != OP_NONE));

endmodule

`default_nettype wire

// ==== rtl/store_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module store_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       commit_valid,
    input  logic [lsu_pkg::XLEN-1:0]   commit_addr,
    input  logic [lsu_pkg::INST_W-1:0] commit_inst_num,
    mem_req_if.dst                     req,
    lookup_if.src                      look,
    output logic                       sb_full
);
    import lsu_pkg::*;

    logic [SB_DEPTH-1:0] entry_valid;
    logic [XLEN-1:0]     entry_addr [SB_DEPTH];
    logic [INST_W-1:0]   entry_inst [SB_DEPTH];
    logic [XLEN-1:0]     entry_data [SB_DEPTH];

    logic [SB_DEPTH-1:0] addr_match;
    logic [SB_DEPTH-1:0] commit_match;
    logic [SB_IDX_W-1:0] match_idx;
    logic [SB_IDX_W-1:0] free_idx;
    logic [SB_IDX_W-1:0] wr_idx;
    logic                any_match;
    logic                is_store;
    logic                is_load;
    logic                st_new;     // Allocate a free entry
    logic                st_replace; // Younger store over same address
    logic                wr_en;
    logic [XLEN-1:0]     store_data;

    assign is_store = req.valid && (req.op inside {OP_SB, OP_SH, OP_SW});
    assign is_load  = req.valid && (req.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});

    // Search by request address and by commit tag; lowest index wins
    always_comb begin
        addr_match   = '0;
        commit_match = '0;
        match_idx    = '0;
        free_idx     = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            addr_match[i]   = entry_valid[i] && (entry_addr[i] == req.addr);
            commit_match[i] = commit_valid && entry_valid[i] &&
                              (entry_addr[i] == commit_addr) &&
                              (entry_inst[i] == commit_inst_num);
            if (addr_match[i]) begin
                match_idx = SB_IDX_W'(i);
            end
            if (!entry_valid[i]) begin
                free_idx = SB_IDX_W'(i);
            end
        end
    end

    assign any_match = |addr_match;
    assign sb_full   = &entry_valid;

    assign st_new     = is_store && !sb_full && !any_match;
    assign st_replace = is_store && !sb_full && any_match &&
                        (req.inst_num > entry_inst[match_idx]); // Older store is dropped
    assign wr_en      = st_new || st_replace;
    assign wr_idx     = st_replace ? match_idx : free_idx;

    always_comb begin
        case (req.op)
            OP_SB:   store_data = {{(XLEN - 8){1'b0}}, req.data[7:0]};
            OP_SH:   store_data = {{(XLEN - 16){1'b0}}, req.data[15:0]};
            default: store_data = req.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= entry_valid & ~commit_match; // Commit frees the entry
            if (wr_en) begin
                entry_valid[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_addr[wr_idx] <= req.addr;
            entry_inst[wr_idx] <= req.inst_num;
            entry_data[wr_idx] <= store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            look.done <= 1'b0;
            look.hit  <= 1'b0;
        end else begin
            look.done <= is_load;
            look.hit  <= is_load && any_match;
        end
    end

    always_ff @(posedge clk) begin
        if (is_load) begin
            look.raw      <= entry_data[match_idx];
            look.op       <= req.op;
            look.phy      <= req.phy;
            look.inst_num <= req.inst_num;
        end
    end

    for (genvar i = 0; i < SB_DEPTH; i++) begin : g_uniq
        for (genvar j = i + 1; j < SB_DEPTH; j++) begin : g_pair
            a_uniq_addr: assert property (@(posedge clk) disable iff (!rst_n)
                !(entry_valid[i] && entry_valid[j] && (entry_addr[i] == entry_addr[j])));
        end
    end

    // Entry contents stay frozen while the buffer is full
    for (genvar i = 0; i < SB_DEPTH; i++) begin : g_full
        a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
            sb_full |=> $stable(entry_addr[i]) && $stable(entry_data[i]) &&
                        $stable(entry_inst[i]));
    end

endmodule

`default_nettype wire

// ==== rtl/load_format.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_format (
    input  logic                       clk,
    input  logic                       rst_n,
    lookup_if.dst                      look,
    output logic [lsu_pkg::XLEN-1:0]   load_data,
    output logic [lsu_pkg::PHY_W-1:0]  load_phy_out,
    output logic [lsu_pkg::INST_W-1:0] load_inst_num,
    output logic                       load_valid,
    output logic                       load_done
);
    import lsu_pkg::*;

    logic [XLEN-1:0] ext_data;

    always_comb begin
        case (look.op)
            OP_LB:   ext_data = {{(XLEN - 8){look.raw[7]}}, look.raw[7:0]};
            OP_LH:   ext_data = {{(XLEN - 16){look.raw[15]}}, look.raw[15:0]};
            OP_LBU:  ext_data = {{(XLEN - 8){1'b0}}, look.raw[7:0]};
            OP_LHU:  ext_data = {{(XLEN - 16){1'b0}}, look.raw[15:0]};
            default: ext_data = look.raw; // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_done  <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            load_done  <= look.done;
            load_valid <= look.done && look.hit;
        end
    end

    always_ff @(posedge clk) begin
        if (look.done) begin
            load_data     <= look.hit ? ext_data : '0; // Zero on a miss
            load_phy_out  <= look.phy;
            load_inst_num <= look.inst_num;
        end
    end

    a_valid_done: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> load_done);

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       mem_write,
    input  logic                       mem_read,
    input  logic [2:0]                 funct3,
    input  logic [lsu_pkg::XLEN-1:0]   mem_addr,
    input  logic [lsu_pkg::XLEN-1:0]   mem_data,
    input  logic [lsu_pkg::INST_W-1:0] inst_num,
    input  logic [lsu_pkg::PHY_W-1:0]  load_phy,
    input  logic                       commit_valid,
    input  logic [lsu_pkg::XLEN-1:0]   commit_addr,
    input  logic [lsu_pkg::INST_W-1:0] commit_inst_num,
    output logic [lsu_pkg::XLEN-1:0]   load_data,
    output logic [lsu_pkg::PHY_W-1:0]  load_phy_out,
    output logic [lsu_pkg::INST_W-1:0] load_inst_num,
    output logic                       load_valid,
    output logic                       load_done,
    output logic                       sb_full
);

    mem_req_if req_bus ();
    lookup_if  look_bus ();

    lsu_dispatch i_dispatch (
        .clk, .rst_n, .flush, .mem_write, .mem_read, .funct3,
        .mem_addr, .mem_data, .inst_num, .load_phy,
        .req (req_bus.src)
    );

    store_buffer i_store_buffer (
        .clk, .rst_n, .flush, .commit_valid, .commit_addr, .commit_inst_num,
        .req     (req_bus.dst),
        .look    (look_bus.src),
        .sb_full (sb_full)
    );

    load_format i_load_format (
        .clk, .rst_n,
        .look (look_bus.dst),
        .load_data, .load_phy_out, .load_inst_num, .load_valid, .load_done
    );

endmodule

`default_nettype wire

// ==== sim/tb_lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              mem_write;
    logic              mem_read;
    logic [2:0]        funct3;
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   mem_data;
    logic [INST_W-1:0] inst_num;
    logic [PHY_W-1:0]  load_phy;
    logic              commit_valid;
    logic [XLEN-1:0]   commit_addr;
    logic [INST_W-1:0] commit_inst_num;
    logic [XLEN-1:0]   load_data;
    logic [PHY_W-1:0]  load_phy_out;
    logic [INST_W-1:0] load_inst_num;
    logic              load_valid;
    logic              load_done;
    logic              sb_full;

    logic [7:0]        vec_cmd [$];
    logic [2:0]        vec_f3 [$];
    logic [XLEN-1:0]   vec_addr [$];
    logic [XLEN-1:0]   vec_data [$];
    logic [INST_W-1:0] vec_inst [$];
    logic [PHY_W-1:0]  vec_phy [$];
    logic              vec_exp_valid [$];
    logic [XLEN-1:0]   vec_exp_data [$];

    int pass_cnt    = 0;
    int fail_cnt    = 0;
    int vec_errors  = 0;
    int group_num   = 1;
    int group_vecs  = 0;
    int group_fails = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0; // Set once the vectors are read

    lsu_top i_lsu_top (
        .clk, .rst_n, .flush, .mem_write, .mem_read, .funct3,
        .mem_addr, .mem_data, .inst_num, .load_phy,
        .commit_valid, .commit_addr, .commit_inst_num,
        .load_data, .load_phy_out, .load_inst_num, .load_valid, .load_done, .sb_full
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    task automatic clear_inputs();
        flush           = 1'b0;
        mem_write       = 1'b0;
        mem_read        = 1'b0;
        funct3          = 3'b000;
        mem_addr        = '0;
        mem_data        = '0;
        inst_num        = '0;
        load_phy        = '0;
        commit_valid    = 1'b0;
        commit_addr     = '0;
        commit_inst_num = '0;
    endtask

    task automatic read_vectors(input int fd);
        string             line;
        int                n;
        logic [7:0]        cmd;
        logic [2:0]        f3;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   data;
        logic [INST_W-1:0] inst;
        logic [PHY_W-1:0]  phy;
        logic              ev;
        logic [XLEN-1:0]   ed;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h %h %h", cmd, f3, addr, data, inst, phy, ev, ed);
            if (n != 8) begin
                $display("Vector file line could not be parsed: %s", line);
                fail_cnt++;
            end else begin
                vec_cmd.push_back(cmd);
                vec_f3.push_back(f3);
                vec_addr.push_back(addr);
                vec_data.push_back(data);
                vec_inst.push_back(inst);
                vec_phy.push_back(phy);
                vec_exp_valid.push_back(ev);
                vec_exp_data.push_back(ed);
            end
        end
    endtask

    task automatic drive_request(input int idx);
        case (vec_cmd[idx])
            "S", "L": begin
                mem_write = (vec_cmd[idx] == "S");
                mem_read  = (vec_cmd[idx] == "L");
                funct3    = vec_f3[idx];
                mem_addr  = vec_addr[idx];
                mem_data  = vec_data[idx];
                inst_num  = vec_inst[idx];
                load_phy  = vec_phy[idx];
            end
            "C": begin
                commit_valid    = 1'b1;
                commit_addr     = vec_addr[idx];
                commit_inst_num = vec_inst[idx];
            end
            "F": flush = 1'b1;
            default: begin
            end
        endcase
    endtask

    task automatic check_load(input int idx);
        assert (load_done) else begin
            $display("Vector %0d: the load gave no load_done pulse in the expected cycle", idx);
            vec_errors++;
        end
        assert (load_valid == vec_exp_valid[idx]) else begin
            $display("MISMATCH at %0t: vector %0d load_valid %b, expected %b",
                     $time, idx, load_valid, vec_exp_valid[idx]);
            vec_errors++;
        end
        assert (load_data == vec_exp_data[idx]) else begin
            $display("MISMATCH at %0t: vector %0d load_data %h, expected %h",
                     $time, idx, load_data, vec_exp_data[idx]);
            vec_errors++;
        end
        assert (load_phy_out == vec_phy[idx] && load_inst_num == vec_inst[idx]) else begin
            $display("MISMATCH at %0t: vector %0d tag %h inst %h, expected tag %h inst %h",
                     $time, idx, load_phy_out, load_inst_num, vec_phy[idx], vec_inst[idx]);
            vec_errors++;
        end
    endtask

    task automatic check_full(input int idx);
        assert (sb_full == vec_exp_valid[idx]) else begin
            $display("MISMATCH at %0t: vector %0d sb_full %b, expected %b",
                     $time, idx, sb_full, vec_exp_valid[idx]);
            vec_errors++;
        end
    endtask

    initial begin
        int fd;
        clk   = 1'b0;
        rst_n = 1'b0;
        clear_inputs();
        fd = $fopen("sim/lsu_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/lsu_input.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            read_vectors(fd);
            $fclose(fd);
            cycle_limit = vec_cmd.size() * 6 + 50;
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            foreach (vec_cmd[i]) begin
                vec_errors = 0;
                drive_request(i);
                @(negedge clk);
                clear_inputs();
                if (vec_cmd[i] == "L") begin
                    repeat (2) @(negedge clk); // Result is three cycles after the request
                    check_load(i);
                end else begin
                    @(negedge clk);
                    check_full(i);
                end
                group_vecs++;
                if (vec_errors == 0) begin
                    pass_cnt++;
                end else begin
                    fail_cnt++;
                    group_fails++;
                end
                if (vec_cmd[i] == "W") begin // Idle line closes a group
                    $display("Group %0d done: %0d vectors, %0d failed",
                             group_num, group_vecs, group_fails);
                    group_num++;
                    group_vecs  = 0;
                    group_fails = 0;
                end
            end
            $display("Totals: %0d vectors passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_top.f ====
rtl/lsu_pkg.sv
rtl/lsu_if.sv
rtl/lsu_dispatch.sv
rtl/store_buffer.sv
rtl/load_format.sv
rtl/lsu_top.sv
sim/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f lsu_top.f --top-module tb_lsu_top \
    -Mdir obj_dir -o tb_lsu_top \
    && ./obj_dir/tb_lsu_top | tee /dev/stderr | grep -qx "Simulation passed" \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

// ==== sim/lsu_input.txt ====
# cmd funct3 addr data inst_num phy exp_valid exp_data, all hex after the command letter
# exp_valid is load_valid on L lines and sb_full on S C F W lines; W closes a group
S 2 00001000 a1b2c3d4 00000010 00 0 00000000
S 1 00001004 0000f0e5 00000011 00 0 00000000
S 0 00001008 12345680 00000012 00 0 00000000
L 2 00001000 00000000 00000020 21 1 a1b2c3d4
L 0 00001008 00000000 00000021 22 1 ffffff80
L 4 00001008 00000000 00000022 23 1 00000080
L 1 00001004 00000000 00000023 24 1 fffff0e5
L 5 00001004 00000000 00000024 25 1 0000f0e5
L 0 00001000 00000000 00000025 26 1 ffffffd4
W 0 00000000 00000000 00000000 00 0 00000000
L 2 00002000 00000000 00000026 30 0 00000000
W 0 00000000 00000000 00000000 00 0 00000000
S 2 00003000 11111111 00000040 00 0 00000000
S 2 00003000 22222222 00000035 00 0 00000000
L 2 00003000 00000000 00000041 31 1 11111111
S 2 00003000 33333333 00000045 00 0 00000000
L 2 00003000 00000000 00000046 32 1 33333333
W 0 00000000 00000000 00000000 00 0 00000000
C 0 00001000 00000000 00000010 00 0 00000000
L 2 00001000 00000000 00000047 33 0 00000000
C 0 00003000 00000000 00000040 00 0 00000000
L 2 00003000 00000000 00000048 34 1 33333333
W 0 00000000 00000000 00000000 00 0 00000000
S 2 00005000 50505050 00000050 00 0 00000000
S 2 00005004 51515151 00000051 00 0 00000000
S 2 00005008 52525252 00000052 00 0 00000000
S 2 0000500c 53535353 00000053 00 0 00000000
S 2 00005010 54545454 00000054 00 1 00000000
S 2 00005014 deadbeef 00000055 00 1 00000000
L 2 00005014 00000000 00000056 40 0 00000000
C 0 00005000 00000000 00000050 00 0 00000000
W 0 00000000 00000000 00000000 00 0 00000000
F 0 00000000 00000000 00000000 00 0 00000000
L 2 00001004 00000000 00000057 41 0 00000000
L 2 00005010 00000000 00000058 42 0 00000000
W 0 00000000 00000000 00000000 00 0 00000000
